// File: all.f
verilog/lsu_types_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsu_byte_lanes.sv
verilog/lsu_load_extender.sv
verilog/lsu_bus_fsm.sv
verilog/lsu_wait_timer.sv
verilog/lsu_fence_tracker.sv
verilog/lsu_top.sv
verif/lsu_clk_gen.sv
verif/lsu_mem_responder.sv
verif/lsu_tb.sv

// File: verif/lsu_tb.sv
////////////////////
// lsu testbench
// random loads and stores, misaligned, bus error, fence
////////////////////
`timescale 1ns/1ps

module lsu_tb;

    localparam int N_LOADS  = 40;
    localparam int N_STORES = 24;
    // misaligned, bus error and fence accesses
    localparam int N_DIRECTED      = 14;
    localparam int NUM_ACCESSES    = N_LOADS + 2 * N_STORES + N_DIRECTED;
    localparam int WATCHDOG_CYCLES =
        NUM_ACCESSES * (lsu_bus_pkg::BUS_TIMEOUT_CYCLES + 12) + 200;

    logic                     CLK;
    logic                     nRST;
    logic                     cpu_req;
    lsu_types_pkg::lsu_req_t  cpu_cmd;
    logic                     cpu_ack;
    lsu_types_pkg::lsu_resp_t cpu_resp;
    logic                     mem_req;
    lsu_bus_pkg::bus_cmd_t    mem_cmd;
    logic                     mem_ack;
    lsu_types_pkg::word_t     mem_rdata;
    logic                     ifence;
    logic                     icache_flush;
    logic                     dcache_flush;
    logic                     iflush_done;
    logic                     dflush_done;
    logic                     fence_stall;
    logic                     no_ack;
    int unsigned              req_count;

    integer                   seed = 32'h5b372ac0;
    lsu_types_pkg::word_t     mirror [256];
    lsu_types_pkg::lsu_resp_t exp_q [$];
    string                    desc_q [$];
    lsu_types_pkg::lsu_resp_t exp_resp;
    string                    exp_desc;
    logic                     ack_seen = 1'b0;
    int                       issued = 0;
    int                       checks = 0;
    int                       i_pulses = 0;
    int                       d_pulses = 0;
    lsu_types_pkg::word_t     raw;
    lsu_types_pkg::word_t     addr;
    lsu_types_pkg::access_e   kind;
    int unsigned              count_before;

    lsu_clk_gen u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    lsu_top u_dut (.*);

    lsu_mem_responder u_mem (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .no_ack    (no_ack),
        .req_count (req_count)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input lsu_types_pkg::word_t got,
                              input lsu_types_pkg::word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s load_data %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_status(input lsu_types_pkg::lsu_status_e got,
                                input lsu_types_pkg::lsu_status_e exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAIL at %0t: %s status %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    function automatic logic is_store(input lsu_types_pkg::access_e k);
        return (k == lsu_types_pkg::SB) || (k == lsu_types_pkg::SH) ||
               (k == lsu_types_pkg::SW);
    endfunction

    function automatic logic is_misaligned(input lsu_types_pkg::access_e k, input logic [1:0] off);
        case (k)
            lsu_types_pkg::LH, lsu_types_pkg::LHU, lsu_types_pkg::SH: return off[0];
            lsu_types_pkg::LW, lsu_types_pkg::SW: return off != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // legal offset for the kind, taken from the random bits
    function automatic lsu_types_pkg::word_t aligned_addr(input lsu_types_pkg::word_t r,
                                                          input lsu_types_pkg::access_e k);
        logic [1:0] off;
        case (k)
            lsu_types_pkg::LH, lsu_types_pkg::LHU, lsu_types_pkg::SH: off = {r[1], 1'b0};
            lsu_types_pkg::LW, lsu_types_pkg::SW: off = 2'b00;
            default: off = r[1:0];
        endcase
        return {22'b0, r[9:2], off};
    endfunction

    // reference model of one access against the mirror memory
    function automatic lsu_types_pkg::lsu_resp_t ref_resp(input lsu_types_pkg::word_t a,
                                                          input lsu_types_pkg::access_e k,
                                                          input logic silent);
        lsu_types_pkg::lsu_resp_t r;
        lsu_types_pkg::word_t     shifted;
        logic [15:0]              half;
        shifted     = mirror[a[9:2]] >> {a[1:0], 3'b000};
        half        = shifted[15:0];
        r.load_data = '0;
        r.status    = lsu_types_pkg::LSU_OK;
        if (is_misaligned(k, a[1:0])) begin
            r.status = lsu_types_pkg::LSU_MISALIGNED;
        end else if (silent) begin
            r.status = lsu_types_pkg::LSU_BUS_ERROR;
        end else begin
            case (k)
                lsu_types_pkg::LB:  r.load_data = {{24{half[7]}}, half[7:0]};
                lsu_types_pkg::LBU: r.load_data = {24'b0, half[7:0]};
                lsu_types_pkg::LH:  r.load_data = {{16{half[15]}}, half};
                lsu_types_pkg::LHU: r.load_data = {16'b0, half};
                lsu_types_pkg::LW:  r.load_data = mirror[a[9:2]];
                default:            r.load_data = '0;
            endcase
        end
        return r;
    endfunction

    function automatic lsu_types_pkg::word_t merge_store(input lsu_types_pkg::word_t old,
                                                         input lsu_types_pkg::word_t data,
                                                         input lsu_types_pkg::access_e k,
                                                         input logic [1:0] off);
        lsu_types_pkg::word_t r;
        r = old;
        case (k)
            lsu_types_pkg::SB: r[{off, 3'b000} +: 8] = data[7:0];
            lsu_types_pkg::SH: r[{off, 3'b000} +: 16] = data[15:0];
            lsu_types_pkg::SW: r = data;
            default: r = old;
        endcase
        return r;
    endfunction

    // called on a falling edge, raises cpu_req with the command
    task automatic start_access(input lsu_types_pkg::word_t a, input lsu_types_pkg::access_e k,
                                input lsu_types_pkg::word_t sdata);
        lsu_types_pkg::lsu_resp_t exp;
        exp = ref_resp(a, k, no_ack);
        exp_q.push_back(exp);
        desc_q.push_back($sformatf("%s at %h", k.name(), a));
        if (is_store(k) && exp.status == lsu_types_pkg::LSU_OK) begin
            mirror[a[9:2]] = merge_store(mirror[a[9:2]], sdata, k, a[1:0]);
        end
        cpu_cmd.addr       = a;
        cpu_cmd.store_data = sdata;
        cpu_cmd.kind       = k;
        cpu_req            = 1'b1;
        issued++;
    endtask

    task automatic finish_access;
        do begin
            @(negedge CLK);
        end while (!cpu_ack);
        cpu_req = 1'b0;
        do begin
            @(negedge CLK);
        end while (cpu_ack);
    endtask

    task automatic do_access(input lsu_types_pkg::word_t a, input lsu_types_pkg::access_e k,
                             input lsu_types_pkg::word_t sdata);
        start_access(a, k, sdata);
        finish_access();
    endtask

    // request must stay unanswered while the fence stall holds
    task automatic hold_off(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            if (cpu_ack) begin
                fail_run("cpu_ack rose while the fence stall should hold the request");
            end else if (!fence_stall) begin
                fail_run("fence_stall dropped before both flush done inputs arrived");
            end
        end
    endtask

    // response check at each rise of cpu_ack, plus flush pulse counts
    always @(negedge CLK) begin
        if (cpu_ack === 1'b1 && !ack_seen) begin
            if (exp_q.size() == 0) begin
                fail_run("cpu_ack rose with no access outstanding");
            end else begin
                exp_resp = exp_q.pop_front();
                exp_desc = desc_q.pop_front();
                check_data(cpu_resp.load_data, exp_resp.load_data, exp_desc);
                check_status(cpu_resp.status, exp_resp.status, exp_desc);
                checks++;
            end
        end
        ack_seen = (cpu_ack === 1'b1);
        if (icache_flush === 1'b1) begin
            i_pulses++;
        end
        if (dcache_flush === 1'b1) begin
            d_pulses++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        fail_run($sformatf("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES));
    end

    initial begin
        cpu_req     = 1'b0;
        cpu_cmd     = '0;
        ifence      = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        no_ack      = 1'b0;
        wait (nRST === 1'b1);
        @(negedge CLK);
        for (int i = 0; i < 256; i++) begin
            mirror[i] = u_mem.mem[i];
        end

        // random aligned loads of every kind
        for (int n = 0; n < N_LOADS; n++) begin
            raw  = $random(seed);
            kind = lsu_types_pkg::access_e'($unsigned($random(seed)) % 5);
            do_access(aligned_addr(raw, kind), kind, '0);
        end

        // stores, each read back as a word
        for (int n = 0; n < N_STORES; n++) begin
            raw  = $random(seed);
            kind = lsu_types_pkg::access_e'(5 + $unsigned($random(seed)) % 3);
            addr = aligned_addr(raw, kind);
            do_access(addr, kind, $random(seed));
            do_access({addr[31:2], 2'b00}, lsu_types_pkg::LW, '0);
        end

        // misaligned accesses never reach the bus
        count_before = req_count;
        do_access(32'h41, lsu_types_pkg::LH, '0);
        do_access(32'h43, lsu_types_pkg::LHU, '0);
        do_access(32'h45, lsu_types_pkg::LW, '0);
        do_access(32'h46, lsu_types_pkg::LW, '0);
        do_access(32'h47, lsu_types_pkg::LW, '0);
        do_access(32'h41, lsu_types_pkg::SH, 32'hdeadbeef);
        do_access(32'h42, lsu_types_pkg::SW, 32'hdeadbeef);
        do_access(32'h43, lsu_types_pkg::SW, 32'hdeadbeef);
        check_count(req_count, count_before, "bus requests during misaligned accesses");
        do_access(32'h40, lsu_types_pkg::LW, '0);

        // silent memory, then recovery
        no_ack = 1'b1;
        do_access(32'h80, lsu_types_pkg::LW, '0);
        do_access(32'h84, lsu_types_pkg::SW, 32'h0badf00d);
        no_ack = 1'b0;
        do_access(32'h80, lsu_types_pkg::LW, '0);
        do_access(32'h84, lsu_types_pkg::LW, '0);

        // fence with staggered flush completion
        ifence = 1'b1;
        do begin
            @(negedge CLK);
        end while (!fence_stall);
        start_access(32'h88, lsu_types_pkg::LW, '0);
        hold_off(5);
        iflush_done = 1'b1;
        @(negedge CLK);
        iflush_done = 1'b0;
        hold_off(7);
        dflush_done = 1'b1;
        @(negedge CLK);
        dflush_done = 1'b0;
        finish_access();
        ifence = 1'b0;
        repeat (3) @(negedge CLK);
        check_count(i_pulses, 1, "icache_flush pulses");
        check_count(d_pulses, 1, "dcache_flush pulses");

        if (exp_q.size() == 0 && checks == issued) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run($sformatf("responses missing, %0d accesses issued and %0d checked",
                               issued, checks));
        end
    end

endmodule

// File: verif/lsu_mem_responder.sv
////////////////////
// behavioral memory on the lsu bus
// random ack delay, optional silence
////////////////////
`timescale 1ns/1ps

module lsu_mem_responder (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  mem_req,
    input  lsu_bus_pkg::bus_cmd_t mem_cmd,
    output logic                  mem_ack,
    output lsu_types_pkg::word_t  mem_rdata,
    input  logic                  no_ack,
    output int unsigned           req_count
);

    lsu_types_pkg::word_t mem [256];
    integer               seed = 32'h5b372ac0;
    int unsigned          delay;
    logic [7:0]           idx;

    // every byte depends on the full word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'ha5, ~8'(i), 8'(i) + 8'h3c, 8'(i * 29)};
        end
    end

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        req_count = 0;
        forever begin
            @(negedge CLK);
            if (nRST === 1'b1 && mem_req === 1'b1) begin
                req_count++;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge CLK);
                if (!no_ack) begin
                    idx = mem_cmd.addr[9:2];
                    for (int b = 0; b < 4; b++) begin
                        if (mem_cmd.wen && mem_cmd.byte_en[b]) begin
                            mem[idx][8*b +: 8] = mem_cmd.wdata[8*b +: 8];
                        end
                    end
                    mem_rdata = mem[idx];
                    mem_ack   = 1'b1;
                end
                // mem_req drops after the ack, or after the bus timeout
                while (mem_req) @(negedge CLK);
                mem_ack = 1'b0;
            end
        end
    end

endmodule

// File: verif/lsu_clk_gen.sv
////////////////////
// lsu testbench clock and reset
////////////////////
`timescale 1ns/1ps

module lsu_clk_gen (
    output logic CLK,
    output logic nRST
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

// File: verilog/lsu_top.sv
////////////////////
// lsu top level
// load-store unit for a small rv32 core
////////////////////
`timescale 1ns/1ps

module lsu_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      cpu_req,
    input  lsu_types_pkg::lsu_req_t   cpu_cmd,
    output logic                      cpu_ack,
    output lsu_types_pkg::lsu_resp_t  cpu_resp,
    output logic                      mem_req,
    output lsu_bus_pkg::bus_cmd_t     mem_cmd,
    input  logic                      mem_ack,
    input  lsu_types_pkg::word_t      mem_rdata,
    input  logic                      ifence,
    output logic                      icache_flush,
    output logic                      dcache_flush,
    input  logic                      iflush_done,
    input  logic                      dflush_done,
    output logic                      fence_stall
);

    lsu_types_pkg::byte_en_t    byte_en;
    lsu_types_pkg::word_t       wdata;
    lsu_types_pkg::word_t       rdata_q;
    lsu_types_pkg::word_t       load_data;
    lsu_types_pkg::lsu_status_e status;
    logic                       misaligned;
    logic                       timeout;
    logic                       timer_run;
    logic                       is_store;

    assign is_store = (cpu_cmd.kind == lsu_types_pkg::SB) ||
                      (cpu_cmd.kind == lsu_types_pkg::SH) ||
                      (cpu_cmd.kind == lsu_types_pkg::SW);

    // word-aligned bus command
    assign mem_cmd.addr    = {cpu_cmd.addr[31:2], 2'b00};
    assign mem_cmd.wdata   = wdata;
    assign mem_cmd.byte_en = byte_en;
    assign mem_cmd.wen     = is_store;

    assign cpu_resp.load_data = load_data;
    assign cpu_resp.status    = status;

    lsu_byte_lanes u_lanes (
        .cmd        (cpu_cmd),
        .byte_en    (byte_en),
        .wdata      (wdata),
        .misaligned (misaligned)
    );

    lsu_load_extender u_ext (
        .rdata     (rdata_q),
        .kind      (cpu_cmd.kind),
        .byte_en   (byte_en),
        .load_data (load_data)
    );

    lsu_bus_fsm u_fsm (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_ack    (cpu_ack),
        .misaligned (misaligned),
        .stall      (fence_stall),
        .timeout    (timeout),
        .timer_run  (timer_run),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .rdata_q    (rdata_q),
        .status     (status)
    );

    lsu_wait_timer u_timer (
        .CLK     (CLK),
        .nRST    (nRST),
        .run     (timer_run),
        .timeout (timeout)
    );

    lsu_fence_tracker u_fence (
        .CLK          (CLK),
        .nRST         (nRST),
        .ifence       (ifence),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .fence_stall  (fence_stall)
    );

endmodule

// File: verilog/lsu_fence_tracker.sv
////////////////////
// lsu fence tracker
// flush pulses and stall until both caches are done
////////////////////
`timescale 1ns/1ps

module lsu_fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    output logic icache_flush,
    output logic dcache_flush,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic fence_stall
);

    logic ifence_q;
    logic flush_pulse;
    logic iflushed;
    logic dflushed;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_q    <= 1'b0;
            flush_pulse <= 1'b0;
            iflushed    <= 1'b1;
            dflushed    <= 1'b1;
        end else begin
            ifence_q    <= ifence;
            flush_pulse <= ifence && !ifence_q;
            // a done in the pulse cycle wins over the clear
            if (iflush_done) begin
                iflushed <= 1'b1;
            end else if (flush_pulse) begin
                iflushed <= 1'b0;
            end
            if (dflush_done) begin
                dflushed <= 1'b1;
            end else if (flush_pulse) begin
                dflushed <= 1'b0;
            end
        end
    end

    assign icache_flush = flush_pulse;
    assign dcache_flush = flush_pulse;

    // pulse cycle covers the gap before the flags clear
    assign fence_stall = flush_pulse || !(iflushed && dflushed);

    single_flush: assert property (@(posedge CLK) disable iff (!nRST)
        icache_flush |=> !icache_flush)
        else $error("icache_flush held for more than one cycle");

endmodule

// File: verilog/lsu_wait_timer.sv
////////////////////
// lsu wait timer
// flags a memory ack that never comes
////////////////////
`timescale 1ns/1ps

module lsu_wait_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic run,
    output logic timeout
);

    logic [lsu_bus_pkg::TIMER_W-1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!timeout) begin
            count <= count + 1'b1;
        end
    end

    // saturates, so timeout holds until run drops
    assign timeout = (count == lsu_bus_pkg::TIMEOUT_COUNT);

endmodule

// File: verilog/lsu_bus_fsm.sv
////////////////////
// lsu bus controller
// core and memory four-phase handshakes
////////////////////
`timescale 1ns/1ps

module lsu_bus_fsm (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         cpu_req,
    output logic                         cpu_ack,
    input  logic                         misaligned,
    input  logic                         stall,
    input  logic                         timeout,
    output logic                         timer_run,
    output logic                         mem_req,
    input  logic                         mem_ack,
    input  lsu_types_pkg::word_t         mem_rdata,
    output lsu_types_pkg::word_t         rdata_q,
    output lsu_types_pkg::lsu_status_e   status
);

    lsu_bus_pkg::bus_state_e state;
    lsu_bus_pkg::bus_state_e next_state;
    logic                    start;

    // request sampled in IDLE unless a fence holds it off
    assign start = (state == lsu_bus_pkg::IDLE) && cpu_req && !stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= lsu_bus_pkg::IDLE;
            status <= lsu_types_pkg::LSU_OK;
        end else begin
            state <= next_state;
            if (start) begin
                status <= misaligned ? lsu_types_pkg::LSU_MISALIGNED : lsu_types_pkg::LSU_OK;
            end else if ((state == lsu_bus_pkg::WAIT_ACK) && !mem_ack && timeout) begin
                status <= lsu_types_pkg::LSU_BUS_ERROR;
            end
        end
    end

    // cleared at start so misaligned and timed-out accesses return zero
    always_ff @(posedge CLK) begin
        if (start) begin
            rdata_q <= '0;
        end else if ((state == lsu_bus_pkg::WAIT_ACK) && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsu_bus_pkg::IDLE: begin
                if (start) begin
                    next_state = misaligned ? lsu_bus_pkg::RESPOND : lsu_bus_pkg::BUS_REQ;
                end
            end
            lsu_bus_pkg::BUS_REQ: begin
                next_state = lsu_bus_pkg::WAIT_ACK;
            end
            lsu_bus_pkg::WAIT_ACK: begin
                if (mem_ack || timeout) begin
                    next_state = lsu_bus_pkg::WAIT_RELEASE;
                end
            end
            lsu_bus_pkg::WAIT_RELEASE: begin
                // memory must drop its ack before the core is answered
                if (!mem_ack) begin
                    next_state = lsu_bus_pkg::RESPOND;
                end
            end
            lsu_bus_pkg::RESPOND: begin
                if (!cpu_req) begin
                    next_state = lsu_bus_pkg::FINISH;
                end
            end
            default: begin
                next_state = lsu_bus_pkg::IDLE;
            end
        endcase
    end

    assign mem_req   = (state == lsu_bus_pkg::BUS_REQ) || (state == lsu_bus_pkg::WAIT_ACK);
    assign timer_run = (state == lsu_bus_pkg::WAIT_ACK);
    assign cpu_ack   = (state == lsu_bus_pkg::RESPOND) || (state == lsu_bus_pkg::FINISH);

    mem_req_rise: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(mem_req) |-> (state == lsu_bus_pkg::BUS_REQ))
        else $error("mem_req rose outside BUS_REQ");

    // core may drop its request as soon as it sees the ack
    ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose with no core request");

endmodule

// File: verilog/lsu_load_extender.sv
////////////////////
// lsu load extender
// picks byte or halfword and extends it
////////////////////
`timescale 1ns/1ps

module lsu_load_extender (
    input  lsu_types_pkg::word_t    rdata,
    input  lsu_types_pkg::access_e  kind,
    input  lsu_types_pkg::byte_en_t byte_en,
    output lsu_types_pkg::word_t    load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // addressed byte from the one-hot enable
    always_comb begin
        case (byte_en)
            4'b0010: sel_byte = rdata[15:8];
            4'b0100: sel_byte = rdata[23:16];
            4'b1000: sel_byte = rdata[31:24];
            default: sel_byte = rdata[7:0];
        endcase
    end

    // upper pair when lane 2 is enabled
    assign sel_half = byte_en[2] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (kind)
            lsu_types_pkg::LB:  load_data = {{24{sel_byte[7]}}, sel_byte};
            lsu_types_pkg::LBU: load_data = {24'b0, sel_byte};
            lsu_types_pkg::LH:  load_data = {{16{sel_half[15]}}, sel_half};
            lsu_types_pkg::LHU: load_data = {16'b0, sel_half};
            lsu_types_pkg::LW:  load_data = rdata;
            // stores return nothing
            default:            load_data = '0;
        endcase
    end

endmodule

// File: verilog/lsu_byte_lanes.sv
////////////////////
// lsu byte lanes
// byte enables, alignment check, store replication
////////////////////
`timescale 1ns/1ps

module lsu_byte_lanes (
    input  lsu_types_pkg::lsu_req_t cmd,
    output lsu_types_pkg::byte_en_t byte_en,
    output lsu_types_pkg::word_t    wdata,
    output logic                    misaligned
);

    logic [1:0] offset;

    assign offset = cmd.addr[1:0];

    // lane enables and alignment from the low address bits
    always_comb begin
        byte_en    = '0;
        misaligned = 1'b0;
        case (cmd.kind)
            lsu_types_pkg::LB,
            lsu_types_pkg::LBU,
            lsu_types_pkg::SB: begin
                byte_en = 4'b0001 << offset;
            end
            lsu_types_pkg::LH,
            lsu_types_pkg::LHU,
            lsu_types_pkg::SH: begin
                misaligned = offset[0];
                if (!offset[0]) begin
                    byte_en = offset[1] ? 4'b1100 : 4'b0011;
                end
            end
            lsu_types_pkg::LW,
            lsu_types_pkg::SW: begin
                misaligned = (offset != 2'b00);
                if (offset == 2'b00) begin
                    byte_en = 4'b1111;
                end
            end
            default: begin
                // unknown kind is kept off the bus
                misaligned = 1'b1;
            end
        endcase
    end

    // store data copied to every lane, memory keeps only the enabled ones
    always_comb begin
        case (cmd.kind)
            lsu_types_pkg::SB: begin
                wdata = {4{cmd.store_data[7:0]}};
            end
            lsu_types_pkg::SH: begin
                wdata = {2{cmd.store_data[15:0]}};
            end
            default: begin
                wdata = cmd.store_data;
            end
        endcase
    end

    lanes_enabled: assert final (misaligned || (byte_en != '0))
        else $error("aligned access with no byte lane enabled");

endmodule

// File: verilog/lsu_bus_pkg.sv
////////////////////
// lsu memory bus types
// bus command, controller states, timeout
////////////////////
package lsu_bus_pkg;

    // word-aligned command held stable while mem_req is high
    typedef struct packed {
        lsu_types_pkg::word_t    addr;
        lsu_types_pkg::word_t    wdata;
        lsu_types_pkg::byte_en_t byte_en;
        logic                    wen;
    } bus_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        BUS_REQ,
        WAIT_ACK,
        WAIT_RELEASE,
        RESPOND,
        FINISH
    } bus_state_e;

    // cycles allowed in WAIT_ACK before a bus error
    localparam int unsigned BUS_TIMEOUT_CYCLES = 16;
    localparam int unsigned TIMER_W = 5;
    localparam logic [TIMER_W-1:0] TIMEOUT_COUNT = TIMER_W'(BUS_TIMEOUT_CYCLES);

endpackage

// File: verilog/lsu_types_pkg.sv
////////////////////
// lsu access types
// core request, response and access kinds
////////////////////
package lsu_types_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // one enable per byte lane, lane 0 at the lowest address
    typedef logic [3:0] byte_en_t;

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } access_e;

    typedef enum logic [1:0] {
        LSU_OK         = 2'd0,
        LSU_MISALIGNED = 2'd1,
        LSU_BUS_ERROR  = 2'd2
    } lsu_status_e;

    typedef struct packed {
        word_t   addr;
        word_t   store_data;
        access_e kind;
    } lsu_req_t;

    typedef struct packed {
        word_t       load_data;
        lsu_status_e status;
    } lsu_resp_t;

endpackage
